/* design/dma_macros.svh */
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// word address and stride width
`define DMA_ADDR_W 16
// data word and register width
`define DMA_DATA_W 32
// words per burst
`define DMA_LEN_W 12
// bursts per job
`define DMA_REPS_W 8
// transfer id, 0 means rejected
`define DMA_ID_W 8
// packed job: src, dst, src stride, dst stride, len, reps
`define DMA_JOB_W 84

// register map
`define DMA_REG_AW 3
`define DMA_REG_SRC 3'd0
`define DMA_REG_DST 3'd1
`define DMA_REG_LEN 3'd2
`define DMA_REG_SRC_STRIDE 3'd3
`define DMA_REG_DST_STRIDE 3'd4
`define DMA_REG_REPS 3'd5
`define DMA_REG_LAUNCH 3'd6
`define DMA_REG_STATUS 3'd7

// job queue entries
`define DMA_FIFO_DEPTH 4

`endif

/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  // word address or stride
  typedef logic [15:0] addr_t;

  // memory word or register value
  typedef logic [31:0] data_t;

  // words per burst
  typedef logic [11:0] len_t;

  // bursts per job
  typedef logic [7:0] reps_t;

  // wrapping transfer id, zero reserved
  typedef logic [7:0] tf_id_t;

  // register offset
  typedef logic [2:0] reg_addr_t;

  // src, dst, src stride, dst stride, len, reps from msb down
  typedef logic [83:0] job_t;

  // word mover states
  typedef enum logic [1:0] {
    MOVER_IDLE,
    MOVER_READ,
    MOVER_WAIT,
    MOVER_WRITE
  } mover_state_t;

endpackage

`default_nettype wire

/* design/dma_reg_frontend.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module dma_reg_frontend (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               reg_req_i,
  input  wire logic               reg_we_i,
  input  wire dma_pkg::reg_addr_t reg_addr_i,
  input  wire dma_pkg::data_t     reg_wdata_i,
  output dma_pkg::data_t          reg_rdata_o,
  output logic                    push_valid_o,
  input  wire logic               push_ready_i,
  output dma_pkg::job_t           job_o,
  input  wire logic               fifo_empty_i,
  input  wire logic               counter_busy_i,
  input  wire logic               job_done_i
);

  import dma_pkg::*;

  // configuration registers
  addr_t  src_q;
  addr_t  dst_q;
  addr_t  src_stride_q;
  addr_t  dst_stride_q;
  len_t   len_q;
  reps_t  reps_q;

  // issue and retire counters
  tf_id_t next_id_q;
  tf_id_t completed_id_q;

  logic   read_req;
  logic   launch_ok;
  logic   busy;
  data_t  status;

  // step an id, skipping the reserved zero
  function automatic tf_id_t id_inc(tf_id_t id);
    tf_id_t nxt;
    nxt = id + 1'b1;
    if (nxt == '0) begin
      nxt = tf_id_t'(1);
    end
    return nxt;
  endfunction

  assign read_req = reg_req_i && !reg_we_i;

  // launch is a read of the launch offset with a nonzero shape
  assign push_valid_o = read_req && (reg_addr_i == `DMA_REG_LAUNCH)
                        && (len_q != '0) && (reps_q != '0);
  // queue full means rejection too
  assign launch_ok = push_valid_o && push_ready_i;

  assign job_o = {src_q, dst_q, src_stride_q, dst_stride_q, len_q, reps_q};

  // anything queued or still in the midend
  assign busy   = !fifo_empty_i || counter_busy_i;
  assign status = data_t'({completed_id_q, 7'b0, busy});

  // register writes land at the strobe edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      len_q        <= '0;
      reps_q       <= '0;
    end else if (reg_req_i && reg_we_i) begin
      case (reg_addr_i)
        `DMA_REG_SRC:        src_q        <= reg_wdata_i[`DMA_ADDR_W-1:0];
        `DMA_REG_DST:        dst_q        <= reg_wdata_i[`DMA_ADDR_W-1:0];
        `DMA_REG_LEN:        len_q        <= reg_wdata_i[`DMA_LEN_W-1:0];
        `DMA_REG_SRC_STRIDE: src_stride_q <= reg_wdata_i[`DMA_ADDR_W-1:0];
        `DMA_REG_DST_STRIDE: dst_stride_q <= reg_wdata_i[`DMA_ADDR_W-1:0];
        `DMA_REG_REPS:       reps_q       <= reg_wdata_i[`DMA_REPS_W-1:0];
        // launch and status ignore writes
        default: ;
      endcase
    end
  end

  // read data one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (read_req) begin
      case (reg_addr_i)
        `DMA_REG_SRC:        reg_rdata_o <= data_t'(src_q);
        `DMA_REG_DST:        reg_rdata_o <= data_t'(dst_q);
        `DMA_REG_LEN:        reg_rdata_o <= data_t'(len_q);
        `DMA_REG_SRC_STRIDE: reg_rdata_o <= data_t'(src_stride_q);
        `DMA_REG_DST_STRIDE: reg_rdata_o <= data_t'(dst_stride_q);
        `DMA_REG_REPS:       reg_rdata_o <= data_t'(reps_q);
        // id of the accepted job, or 0 if rejected
        `DMA_REG_LAUNCH:     reg_rdata_o <= launch_ok ? data_t'(next_id_q) : '0;
        default:             reg_rdata_o <= status;
      endcase
    end
  end

  // ids retire in issue order, so both count the same way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      next_id_q      <= tf_id_t'(1);
      completed_id_q <= '0;
    end else begin
      if (launch_ok) begin
        next_id_q <= id_inc(next_id_q);
      end
      if (job_done_i) begin
        completed_id_q <= id_inc(completed_id_q);
      end
    end
  end

  // a retirement always has an issued id still outstanding
  a_retire_after_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    job_done_i |-> (id_inc(completed_id_q) != next_id_q));

endmodule

`default_nettype wire

/* design/dma_job_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module dma_job_fifo #(
  parameter int unsigned DEPTH = `DMA_FIFO_DEPTH
) (
  input  wire logic           clk_i,
  input  wire logic           reset_i,
  input  wire logic           push_valid_i,
  output logic                push_ready_o,
  input  wire dma_pkg::job_t  job_i,
  output logic                pop_valid_o,
  input  wire logic           pop_ready_i,
  output dma_pkg::job_t       job_o,
  output logic                empty_o
);

  import dma_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // circular storage
  job_t             mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign job_o        = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // payload store
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= job_i;
    end
  end

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // full buffer has the write slot on the unread head
  a_full_ptrs: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q == CNT_W'(DEPTH)) |-> (wr_ptr_q == rd_ptr_q));

  // empty buffer has both pointers on the same slot
  a_empty_ptrs: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q == '0) |-> (wr_ptr_q == rd_ptr_q));

endmodule

`default_nettype wire

/* design/dma_rep_counter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module dma_rep_counter (
  input  wire logic           clk_i,
  input  wire logic           reset_i,
  input  wire logic           job_valid_i,
  output logic                job_ready_o,
  input  wire dma_pkg::job_t  job_i,
  output logic                burst_valid_o,
  input  wire logic           burst_ready_i,
  output dma_pkg::addr_t      burst_src_o,
  output dma_pkg::addr_t      burst_dst_o,
  output dma_pkg::len_t       burst_len_o,
  input  wire logic           burst_done_i,
  output logic                job_done_o,
  output logic                busy_o
);

  import dma_pkg::*;

  // unpacked job fields
  addr_t j_src;
  addr_t j_dst;
  addr_t j_src_stride;
  addr_t j_dst_stride;
  len_t  j_len;
  reps_t j_reps;

  // current job
  logic  busy_q;
  addr_t src_base_q;
  addr_t dst_base_q;
  addr_t src_stride_q;
  addr_t dst_stride_q;
  len_t  len_q;
  // bursts still to issue, bursts still to finish
  logic [`DMA_REPS_W-1:0] issue_left_q;
  logic [`DMA_REPS_W-1:0] done_left_q;

  logic  accept;
  logic  issue;

  assign {j_src, j_dst, j_src_stride, j_dst_stride, j_len, j_reps} = job_i;

  // one job at a time
  assign job_ready_o = !busy_q;
  assign accept      = job_valid_i && job_ready_o;
  assign busy_o      = busy_q;

  // next burst offered while earlier ones may still be moving
  assign burst_valid_o = busy_q && (issue_left_q != '0);
  assign burst_src_o   = src_base_q;
  assign burst_dst_o   = dst_base_q;
  assign burst_len_o   = len_q;
  assign issue         = burst_valid_o && burst_ready_i;

  // last outstanding completion ends the job
  assign job_done_o = burst_done_i && (done_left_q == `DMA_REPS_W'(1));

  // shape and strides, held for the whole job
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_stride_q <= j_src_stride;
      dst_stride_q <= j_dst_stride;
      len_q        <= j_len;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q       <= 1'b0;
      src_base_q   <= '0;
      dst_base_q   <= '0;
      issue_left_q <= '0;
      done_left_q  <= '0;
    end else if (accept) begin
      busy_q       <= 1'b1;
      src_base_q   <= j_src;
      dst_base_q   <= j_dst;
      issue_left_q <= j_reps;
      done_left_q  <= j_reps;
    end else begin
      // step both bases by their stride per issued burst
      if (issue) begin
        src_base_q   <= src_base_q + src_stride_q;
        dst_base_q   <= dst_base_q + dst_stride_q;
        issue_left_q <= issue_left_q - 1'b1;
      end
      if (burst_done_i) begin
        done_left_q <= done_left_q - 1'b1;
      end
      if (job_done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // mover only reports bursts this counter has already handed over
  a_done_after_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    burst_done_i |-> busy_q && (done_left_q > issue_left_q));

endmodule

`default_nettype wire

/* design/dma_word_mover.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module dma_word_mover (
  input  wire logic            clk_i,
  input  wire logic            reset_i,
  input  wire logic            burst_valid_i,
  output logic                 burst_ready_o,
  input  wire dma_pkg::addr_t  burst_src_i,
  input  wire dma_pkg::addr_t  burst_dst_i,
  input  wire dma_pkg::len_t   burst_len_i,
  output logic                 burst_done_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output dma_pkg::addr_t       mem_addr_o,
  output dma_pkg::data_t       mem_wdata_o,
  input  wire logic            mem_gnt_i,
  input  wire dma_pkg::data_t  mem_rdata_i
);

  import dma_pkg::*;

  mover_state_t state_q;

  // burst bases
  addr_t src_q;
  addr_t dst_q;
  // word offset into the burst and words left
  logic [`DMA_LEN_W-1:0] off_q;
  logic [`DMA_LEN_W-1:0] left_q;
  // word in flight
  data_t data_q;
  logic  done_q;

  // new burst only taken while idle
  assign burst_ready_o = (state_q == MOVER_IDLE);
  assign burst_done_o  = done_q;

  // read phase uses src, write phase uses dst
  assign mem_req_o   = (state_q == MOVER_READ) || (state_q == MOVER_WRITE);
  assign mem_we_o    = (state_q == MOVER_WRITE);
  assign mem_addr_o  = mem_we_o ? dst_q + addr_t'(off_q) : src_q + addr_t'(off_q);
  assign mem_wdata_o = data_q;

  // burst bases latched at acceptance
  always_ff @(posedge clk_i) begin
    if (burst_valid_i && burst_ready_o) begin
      src_q <= burst_src_i;
      dst_q <= burst_dst_i;
    end
  end

  // read data arrives exactly one cycle after the read grant
  always_ff @(posedge clk_i) begin
    if (state_q == MOVER_WAIT) begin
      data_q <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= MOVER_IDLE;
      off_q   <= '0;
      left_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        MOVER_IDLE: begin
          if (burst_valid_i) begin
            off_q   <= '0;
            left_q  <= burst_len_i;
            state_q <= MOVER_READ;
          end
        end
        // stall in place until granted
        MOVER_READ: begin
          if (mem_gnt_i) begin
            state_q <= MOVER_WAIT;
          end
        end
        MOVER_WAIT: begin
          state_q <= MOVER_WRITE;
        end
        MOVER_WRITE: begin
          if (mem_gnt_i) begin
            off_q  <= off_q + 1'b1;
            left_q <= left_q - 1'b1;
            // final word done
            if (left_q == `DMA_LEN_W'(1)) begin
              done_q  <= 1'b1;
              state_q <= MOVER_IDLE;
            end else begin
              state_q <= MOVER_READ;
            end
          end
        end
        default: begin
          state_q <= MOVER_IDLE;
        end
      endcase
    end
  end

  // an ungranted request holds its fields into the next cycle
  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
                                && $stable(mem_wdata_o));

endmodule

`default_nettype wire

/* design/dma_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module dma_core (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               reg_req_i,
  input  wire logic               reg_we_i,
  input  wire dma_pkg::reg_addr_t reg_addr_i,
  input  wire dma_pkg::data_t     reg_wdata_i,
  output dma_pkg::data_t          reg_rdata_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output dma_pkg::addr_t          mem_addr_o,
  output dma_pkg::data_t          mem_wdata_o,
  input  wire logic               mem_gnt_i,
  input  wire dma_pkg::data_t     mem_rdata_i
);

  import dma_pkg::*;

  // frontend to queue
  logic  push_valid;
  logic  push_ready;
  job_t  fe_job;
  logic  fifo_empty;

  // queue to midend
  logic  job_valid;
  logic  job_ready;
  job_t  q_job;

  // midend to mover
  logic  burst_valid;
  logic  burst_ready;
  addr_t burst_src;
  addr_t burst_dst;
  len_t  burst_len;
  logic  burst_done;

  // completion and status back to the frontend
  logic  job_done;
  logic  counter_busy;

  dma_reg_frontend i_frontend (
    .clk_i,
    .reset_i,
    .reg_req_i,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .push_valid_o   ( push_valid   ),
    .push_ready_i   ( push_ready   ),
    .job_o          ( fe_job       ),
    .fifo_empty_i   ( fifo_empty   ),
    .counter_busy_i ( counter_busy ),
    .job_done_i     ( job_done     )
  );

  dma_job_fifo #(
    .DEPTH ( `DMA_FIFO_DEPTH )
  ) i_job_fifo (
    .clk_i,
    .reset_i,
    .push_valid_i ( push_valid ),
    .push_ready_o ( push_ready ),
    .job_i        ( fe_job     ),
    .pop_valid_o  ( job_valid  ),
    .pop_ready_i  ( job_ready  ),
    .job_o        ( q_job      ),
    .empty_o      ( fifo_empty )
  );

  dma_rep_counter i_rep_counter (
    .clk_i,
    .reset_i,
    .job_valid_i   ( job_valid    ),
    .job_ready_o   ( job_ready    ),
    .job_i         ( q_job        ),
    .burst_valid_o ( burst_valid  ),
    .burst_ready_i ( burst_ready  ),
    .burst_src_o   ( burst_src    ),
    .burst_dst_o   ( burst_dst    ),
    .burst_len_o   ( burst_len    ),
    .burst_done_i  ( burst_done   ),
    .job_done_o    ( job_done     ),
    .busy_o        ( counter_busy )
  );

  dma_word_mover i_word_mover (
    .clk_i,
    .reset_i,
    .burst_valid_i ( burst_valid ),
    .burst_ready_o ( burst_ready ),
    .burst_src_i   ( burst_src   ),
    .burst_dst_i   ( burst_dst   ),
    .burst_len_i   ( burst_len   ),
    .burst_done_o  ( burst_done  ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rdata_i
  );

endmodule

`default_nettype wire

/* bench/tb_dma_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dma_macros.svh"

module tb_dma_core;

  import dma_pkg::*;

  localparam int MEM_WORDS = 65536;
  localparam int TESTS = 5;
  // 8 + 3*5 + 4 + 5*(2*6) words over all tests
  localparam int MOVED_WORDS = 87;
  localparam int CYCLE_LIMIT = 8 * MOVED_WORDS + 200 * TESTS;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      reg_req_i;
  logic      reg_we_i;
  reg_addr_t reg_addr_i;
  data_t     reg_wdata_i;
  data_t     reg_rdata_o;
  logic      mem_req_o;
  logic      mem_we_o;
  addr_t     mem_addr_o;
  data_t     mem_wdata_o;
  logic      mem_gnt_i = 1'b0;
  data_t     mem_rdata_i = '0;

  // memory model state
  data_t       mem [MEM_WORDS];
  logic        rand_gnt = 1'b0;
  logic [31:0] lcg_state = 32'hca9c_7d78;
  logic [31:0] lcg_word;
  int unsigned cycle_cnt = 0;

  // expected id bookkeeping
  tf_id_t next_id;
  tf_id_t last_id;

  dma_core i_dut (
    .clk_i,
    .reset_i,
    .reg_req_i,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rdata_i
  );

  always #20 clk_i = ~clk_i;

  // numerical recipes constants, upper bits used for grant
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // initial memory content, every address bit matters
  function automatic data_t fill_word(addr_t a);
    return {~a, a} ^ 32'h3c5a_96e1;
  endfunction

  // id sequence wraps past the reserved zero
  function automatic tf_id_t step_id(tf_id_t id);
    tf_id_t nxt;
    nxt = id + 8'd1;
    return (nxt == 8'd0) ? 8'd1 : nxt;
  endfunction

  // word memory with grant, read data one cycle after a granted read
  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        mem[addr_t'(a)] = fill_word(addr_t'(a));
      end
      mem_gnt_i   <= 1'b0;
      mem_rdata_i <= '0;
    end else begin
      lcg_word = lcg_next();
      // about three grants out of four in random mode
      mem_gnt_i <= rand_gnt ? (lcg_word[31:30] != 2'b00) : 1'b1;
      if (mem_req_o && mem_gnt_i) begin
        if (mem_we_o) begin
          mem[mem_addr_o] = mem_wdata_o;
        end else begin
          mem_rdata_i <= mem[mem_addr_o];
        end
      end
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, engine never finished", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  task automatic check_id(input string name, input tf_id_t got, input tf_id_t exp);
    if (got !== exp) begin
      $display("Fail %s exp %h got %h", name, exp, got);
      $display("Test failed");
      $fatal(1, "id mismatch on %s", name);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Fail %s exp %h got %h", name, exp, got);
      $display("Test failed");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  // one-cycle write strobe
  task automatic reg_write(input reg_addr_t addr, input data_t wdata);
    @(posedge clk_i);
    reg_req_i   <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    reg_we_i  <= 1'b0;
  endtask

  // read data sampled mid-cycle after the strobe edge
  task automatic reg_read(input reg_addr_t addr, output data_t rdata);
    @(posedge clk_i);
    reg_req_i  <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= addr;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    @(negedge clk_i);
    rdata = reg_rdata_o;
  endtask

  task automatic readback(input reg_addr_t addr, input string name, input data_t exp);
    data_t rdata;
    reg_read(addr, rdata);
    check_data(name, rdata, exp);
  endtask

  task automatic program_job(input addr_t src, input addr_t dst, input addr_t src_stride,
                             input addr_t dst_stride, input len_t len, input reps_t reps);
    reg_write(`DMA_REG_SRC, data_t'(src));
    reg_write(`DMA_REG_DST, data_t'(dst));
    reg_write(`DMA_REG_SRC_STRIDE, data_t'(src_stride));
    reg_write(`DMA_REG_DST_STRIDE, data_t'(dst_stride));
    reg_write(`DMA_REG_LEN, data_t'(len));
    reg_write(`DMA_REG_REPS, data_t'(reps));
  endtask

  task automatic launch_accept();
    data_t rdata;
    reg_read(`DMA_REG_LAUNCH, rdata);
    check_id("launch id", tf_id_t'(rdata[7:0]), next_id);
    last_id = next_id;
    next_id = step_id(next_id);
  endtask

  task automatic launch_reject();
    data_t rdata;
    reg_read(`DMA_REG_LAUNCH, rdata);
    check_id("rejected launch id", tf_id_t'(rdata[7:0]), 8'd0);
  endtask

  // poll until the given id retired and nothing is left in flight
  task automatic wait_idle(input tf_id_t exp_done);
    data_t status;
    do begin
      reg_read(`DMA_REG_STATUS, status);
    end while ((status[15:8] != exp_done) || status[0]);
    check_data("status", status, data_t'({exp_done, 8'h00}));
  endtask

  task automatic check_copy(input addr_t src, input addr_t dst, input addr_t src_stride,
                            input addr_t dst_stride, input int len, input int reps);
    addr_t s;
    addr_t d;
    for (int r = 0; r < reps; r++) begin
      for (int i = 0; i < len; i++) begin
        s = addr_t'(src + r * src_stride + i);
        d = addr_t'(dst + r * dst_stride + i);
        check_data($sformatf("mem[%h]", d), mem[d], fill_word(s));
      end
    end
  endtask

  task automatic check_untouched(input addr_t a);
    check_data($sformatf("mem[%h]", a), mem[a], fill_word(a));
  endtask

  task automatic test_readback();
    readback(`DMA_REG_STATUS, "status", 32'h0000_0000);
    // upper bits beyond each field width are dropped
    reg_write(`DMA_REG_SRC, 32'hdead_1234);
    reg_write(`DMA_REG_DST, 32'h0000_abcd);
    reg_write(`DMA_REG_LEN, 32'hffff_f5a3);
    reg_write(`DMA_REG_SRC_STRIDE, 32'h0001_0040);
    reg_write(`DMA_REG_DST_STRIDE, 32'h0000_ff01);
    reg_write(`DMA_REG_REPS, 32'h0000_01c3);
    readback(`DMA_REG_SRC, "reg src", 32'h0000_1234);
    readback(`DMA_REG_DST, "reg dst", 32'h0000_abcd);
    readback(`DMA_REG_LEN, "reg len", 32'h0000_05a3);
    readback(`DMA_REG_SRC_STRIDE, "reg src stride", 32'h0000_0040);
    readback(`DMA_REG_DST_STRIDE, "reg dst stride", 32'h0000_ff01);
    readback(`DMA_REG_REPS, "reg reps", 32'h0000_00c3);
    readback(`DMA_REG_STATUS, "status", 32'h0000_0000);
  endtask

  task automatic test_copy_1d();
    program_job(16'h0100, 16'h0200, 16'd0, 16'd0, 12'd8, 8'd1);
    launch_accept();
    wait_idle(last_id);
    check_copy(16'h0100, 16'h0200, 16'd0, 16'd0, 8, 1);
    // neighbours of the destination
    check_untouched(16'h01ff);
    check_untouched(16'h0208);
  endtask

  task automatic test_copy_2d();
    program_job(16'h1000, 16'h2000, 16'd16, 16'd7, 12'd5, 8'd3);
    launch_accept();
    wait_idle(last_id);
    check_copy(16'h1000, 16'h2000, 16'd16, 16'd7, 5, 3);
    // gaps between destination rows
    check_untouched(16'h2005);
    check_untouched(16'h2006);
    check_untouched(16'h200c);
    check_untouched(16'h200d);
    check_untouched(16'h2013);
  endtask

  task automatic test_reject();
    // zero length
    program_job(16'h3100, 16'h3000, 16'd0, 16'd0, 12'd0, 8'd2);
    launch_reject();
    // zero repetitions
    reg_write(`DMA_REG_LEN, 32'd4);
    reg_write(`DMA_REG_REPS, 32'd0);
    launch_reject();
    readback(`DMA_REG_STATUS, "status", data_t'({last_id, 8'h00}));
    for (int i = 0; i < 8; i++) begin
      check_untouched(addr_t'(16'h3000 + i));
    end
    reg_write(`DMA_REG_REPS, 32'd1);
    launch_accept();
    wait_idle(last_id);
    check_copy(16'h3100, 16'h3000, 16'd0, 16'd0, 4, 1);
    check_untouched(16'h3004);
  endtask

  task automatic test_queue_backpressure();
    addr_t src;
    addr_t dst;
    rand_gnt = 1'b1;
    program_job(16'h4000, 16'h5000, 16'd8, 16'd6, 12'd6, 8'd2);
    // first job moves on to the counter, the next four fill the queue
    for (int k = 0; k < 5; k++) begin
      src = addr_t'(32'h4000 + k * 64);
      dst = addr_t'(32'h5000 + k * 64);
      reg_write(`DMA_REG_SRC, data_t'(src));
      reg_write(`DMA_REG_DST, data_t'(dst));
      launch_accept();
    end
    // queue full while the first job is still moving
    launch_reject();
    wait_idle(last_id);
    for (int k = 0; k < 5; k++) begin
      src = addr_t'(32'h4000 + k * 64);
      dst = addr_t'(32'h5000 + k * 64);
      check_copy(src, dst, 16'd8, 16'd6, 6, 2);
    end
    rand_gnt = 1'b0;
  endtask

  initial begin
    reset_i     = 1'b1;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    next_id     = 8'd1;
    last_id     = 8'd0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    test_readback();
    test_copy_1d();
    test_copy_2d();
    test_reject();
    test_queue_backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/dma_pkg.sv
design/dma_reg_frontend.sv
design/dma_job_fifo.sv
design/dma_rep_counter.sv
design/dma_word_mover.sv
design/dma_core.sv
bench/tb_dma_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dma_core -f tb.f -o tb_dma_core_sim
./obj_dir/tb_dma_core_sim | tee sim.log

if grep -q '^Test passed$' sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
